//--- tlu_controller.f
design/tlu_pkg.sv
design/tlu_trigger_unit.sv
design/tlu_event_fifo.sv
design/tlu_wb_regs.sv
design/tlu_controller.sv
verification/tlu_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the TLU controller testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tlu_controller_tb \
    -f tlu_controller.f --Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtlu_controller_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
exit 0

//--- verification/tlu_controller_tb.sv
// Testbench for the TLU controller
//   clock, reset and watchdog
//   LFSR for pulse widths and gaps
//   Wishbone read and write tasks, event word readback
//   directed tests for modes, veto, handshake, overflow and trigger reset

`timescale 1ns/10ps

module tlu_controller_tb;
    import tlu_pkg::*;

    // each pulse is at most 18 cycles, then 10 settle cycles and a few 3-cycle bus reads
    localparam int max_pulses = 60;
    localparam int cycles_per_pulse = 500;
    localparam int watchdog_cycles = max_pulses * cycles_per_pulse;
    localparam int ack_limit = 16;

    logic BUS_CLK;
    logic RST;
    logic rj45_trigger;
    logic lemo_trigger;
    logic rj45_reset;
    logic lemo_reset;
    logic ext_veto;
    logic rj45_enabled;
    logic tlu_busy;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [wb_adr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic wb_ack;
    logic [31:0] lfsr_state;
    int expected_number;

    tlu_controller tlu_controller_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .rj45_trigger(rj45_trigger),
        .lemo_trigger(lemo_trigger),
        .rj45_reset(rj45_reset),
        .lemo_reset(lemo_reset),
        .ext_veto(ext_veto),
        .rj45_enabled(rj45_enabled),
        .tlu_busy(tlu_busy),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    task automatic value_error(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic run_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped after a run error");
    endtask

    initial
    begin
        repeat (watchdog_cycles) @(posedge BUS_CLK);
        run_error($sformatf("timeout: tests did not finish in %0d cycles", watchdog_cycles));
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic [1:0] mode, input bit invert,
                                             input bit veto_off, input bit reset_on,
                                             input bit ts);
        logic [7:0] value;
        value = '0;
        value[ctrl_mode_msb:ctrl_mode_lsb] = mode;
        value[ctrl_invert_lemo] = invert;
        value[ctrl_disable_veto] = veto_off;
        value[ctrl_enable_reset] = reset_on;
        value[ctrl_write_ts] = ts;
        return value;
    endfunction

    // level in the upper nibble, empty flag in bit 0
    function automatic logic [7:0] status_byte(input int fill);
        return {4'(fill), 3'b000, fill == 0};
    endfunction

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge BUS_CLK);
    endtask

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge BUS_CLK);
            cycles++;
        end
        while (!wb_ack && cycles < ack_limit);
        assert (wb_ack === 1'b1)
            else run_error($sformatf("no wb_ack from the DUT within %0d cycles", ack_limit));
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [7:0] data);
        @(posedge BUS_CLK);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge BUS_CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [7:0] data);
        @(posedge BUS_CLK);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        @(posedge BUS_CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // the read of the top byte pops the FIFO
    task automatic read_event(output logic [31:0] word);
        logic [7:0] data;
        for (int b = 0; b < 4; b++)
        begin
            wb_read(reg_fifo_data + 4'(b), data);
            word[8*b +: 8] = data;
        end
    endtask

    task automatic expect_read(input logic [3:0] adr, input logic [7:0] expected,
                               input string what);
        logic [7:0] data;
        wb_read(adr, data);
        assert (data === expected)
            else value_error($sformatf("%s read 0x%02h, expected 0x%02h", what, data, expected));
    endtask

    task automatic expect_event(input logic [31:0] expected, input string what);
        logic [31:0] word;
        read_event(word);
        assert (word === expected)
            else value_error($sformatf("%s 0x%08h, expected 0x%08h", what, word, expected));
    endtask

    task automatic check_timestamps(input int count, inout logic [30:0] last_ts);
        logic [31:0] word;
        for (int i = 0; i < count; i++)
        begin
            read_event(word);
            assert (word[31] === 1'b0) else value_error("timestamp word with kind bit set");
            assert (word[30:0] > last_ts)
                else value_error($sformatf("timestamp 0x%08h not above 0x%08h",
                                           word[30:0], last_ts));
            last_ts = word[30:0];
        end
    endtask

    // random width and gap of 2 to 9 cycles, then 10 cycles to settle
    task automatic lemo_pulses(input int count, input bit active_low);
        int width;
        int gap;
        for (int p = 0; p < count; p++)
        begin
            width = 2 + random_bits(3);
            gap = 2 + random_bits(3);
            @(posedge BUS_CLK);
            lemo_trigger <= !active_low;
            wait_cycles(width);
            lemo_trigger <= active_low;
            wait_cycles(gap);
        end
        wait_cycles(10);
    endtask

    task automatic lemo_reset_pulse();
        @(posedge BUS_CLK);
        lemo_reset <= 1'b1;
        wait_cycles(3);
        lemo_reset <= 1'b0;
        wait_cycles(5);
    endtask

    task automatic test_reset_state();
        expect_read(reg_ctrl, 8'h00, "control register");
        expect_read(reg_lost, 8'h00, "lost count");
        expect_read(reg_fifo_status, status_byte(0), "FIFO status");
        for (int b = 0; b < 4; b++)
            expect_read(reg_trigger_number + 4'(b), 8'h00, "trigger number");
        @(negedge BUS_CLK);
        assert (rj45_enabled === 1'b0) else value_error("rj45_enabled high after reset");
        assert (tlu_busy === 1'b0) else value_error("tlu_busy high after reset");
    endtask

    task automatic test_no_handshake_lemo();
        logic [31:0] preset;
        logic [31:0] snapshot;
        logic [7:0] data;
        int count;
        count = 6;
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 0, 0, 0, 0));
        wait_cycles(5);
        @(negedge BUS_CLK);
        assert (rj45_enabled === 1'b0) else value_error("rj45_enabled with RJ45 lines high");
        lemo_pulses(count, 0);
        expect_read(reg_fifo_status, status_byte(count), "status after LEMO pulses");
        for (int i = 0; i < count; i++)
        begin
            expect_event({1'b1, 31'(expected_number)}, "LEMO event");
            expected_number++;
        end
        preset = 32'd1000;
        for (int b = 0; b < 4; b++)
            wb_write(reg_set_number + 4'(b), preset[8*b +: 8]);
        expected_number = 1000;
        lemo_pulses(1, 0);
        expect_event({1'b1, 31'(expected_number)}, "event after preset");
        expected_number++;
        // address 12 latches the snapshot for 13 to 15
        for (int b = 0; b < 4; b++)
        begin
            wb_read(reg_trigger_number + 4'(b), data);
            snapshot[8*b +: 8] = data;
        end
        assert (snapshot === {1'b0, 31'(expected_number)})
            else value_error($sformatf("snapshot 0x%08h, expected %0d", snapshot, expected_number));
    endtask

    task automatic test_timestamp_veto();
        logic [30:0] last_ts;
        last_ts = '0;
        wb_write(reg_ctrl, ctrl_byte(mode_disabled, 1, 0, 0, 0));
        @(posedge BUS_CLK);
        lemo_trigger <= 1'b1;
        wait_cycles(5);
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 1, 0, 0, 1));
        // low-active pulse is taken on its leading edge
        @(posedge BUS_CLK);
        lemo_trigger <= 1'b0;
        wait_cycles(5);
        expect_read(reg_fifo_status, status_byte(1), "status while low-active pulse held");
        @(posedge BUS_CLK);
        lemo_trigger <= 1'b1;
        wait_cycles(2);
        lemo_pulses(3, 1);
        expect_read(reg_fifo_status, status_byte(4), "status after low-active pulses");
        check_timestamps(4, last_ts);
        @(posedge BUS_CLK);
        ext_veto <= 1'b1;
        wait_cycles(5);
        lemo_pulses(3, 1);
        expect_read(reg_fifo_status, status_byte(0), "status under veto");
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 1, 1, 0, 1));
        lemo_pulses(3, 1);
        expect_read(reg_fifo_status, status_byte(3), "status with veto disabled");
        check_timestamps(3, last_ts);
        expected_number += 7;
        @(posedge BUS_CLK);
        ext_veto <= 1'b0;
        wb_write(reg_ctrl, ctrl_byte(mode_disabled, 0, 0, 0, 0));
        @(posedge BUS_CLK);
        lemo_trigger <= 1'b0;
        wait_cycles(5);
    endtask

    task automatic test_rj45_handshake();
        wb_write(reg_ctrl, ctrl_byte(mode_simple_handshake, 0, 0, 0, 0));
        @(posedge BUS_CLK);
        rj45_trigger <= 1'b0;
        rj45_reset <= 1'b0;
        wait_cycles(5);
        @(negedge BUS_CLK);
        assert (rj45_enabled === 1'b1) else value_error("rj45_enabled low with RJ45 plugged");
        @(posedge BUS_CLK);
        rj45_trigger <= 1'b1;
        wait_busy(1'b1);
        wait_cycles(6);
        @(negedge BUS_CLK);
        assert (tlu_busy === 1'b1) else value_error("tlu_busy fell while trigger held");
        @(posedge BUS_CLK);
        rj45_trigger <= 1'b0;
        wait_busy(1'b0);
        // LEMO is not selected now
        lemo_pulses(3, 0);
        expect_read(reg_fifo_status, status_byte(1), "status after RJ45 trigger");
        expect_event({1'b1, 31'(expected_number)}, "RJ45 event");
        expected_number++;
    endtask

    task automatic wait_busy(input logic value);
        int cycles;
        cycles = 0;
        while (tlu_busy !== value && cycles < 20)
        begin
            @(negedge BUS_CLK);
            cycles++;
        end
        assert (tlu_busy === value)
            else run_error($sformatf("tlu_busy did not go to %0b within 20 cycles", value));
    endtask

    task automatic test_overflow_reset();
        wb_write(reg_ctrl, ctrl_byte(mode_disabled, 0, 0, 0, 0));
        @(posedge BUS_CLK);
        rj45_trigger <= 1'b1;
        rj45_reset <= 1'b1;
        wait_cycles(5);
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 0, 0, 0, 0));
        @(negedge BUS_CLK);
        assert (rj45_enabled === 1'b0) else value_error("rj45_enabled after unplugging");
        lemo_pulses(10, 0);
        expect_read(reg_fifo_status, status_byte(fifo_depth), "status after overflow");
        expect_read(reg_lost, 8'd2, "lost count after overflow");
        for (int i = 0; i < fifo_depth; i++)
            expect_event({1'b1, 31'(expected_number + i)}, "event after overflow");
        expected_number += 10;
        expect_read(reg_fifo_status, status_byte(0), "status after draining");
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 0, 0, 1, 0));
        lemo_reset_pulse();
        lemo_pulses(1, 0);
        expect_event({1'b1, 31'd0}, "event after trigger reset");
        wb_write(reg_ctrl, ctrl_byte(mode_no_handshake, 0, 0, 0, 0));
        lemo_reset_pulse();
        lemo_pulses(1, 0);
        expect_event({1'b1, 31'd1}, "event with trigger reset gated off");
    endtask

    initial
    begin
        lfsr_state = 32'hd580;
        expected_number = 0;
        RST = 1'b1;
        rj45_trigger = 1'b1;
        rj45_reset = 1'b1;
        lemo_trigger = 1'b0;
        lemo_reset = 1'b0;
        ext_veto = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;
        test_reset_state();
        test_no_handshake_lemo();
        test_timestamp_veto();
        test_rj45_handshake();
        test_overflow_reset();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- design/tlu_controller.sv
// TLU controller top level
//   trigger unit feeding the event FIFO
//   Wishbone register block reading the FIFO and configuring the trigger unit

`timescale 1ns/10ps

module tlu_controller (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic rj45_trigger,
    input  logic lemo_trigger,
    input  logic rj45_reset,
    input  logic lemo_reset,
    input  logic ext_veto,
    output logic rj45_enabled,
    output logic tlu_busy,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [tlu_pkg::wb_adr_width-1:0] wb_adr,
    input  logic [tlu_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [tlu_pkg::wb_data_width-1:0] wb_dat_r,
    output logic wb_ack
);
    import tlu_pkg::*;

    logic [1:0] mode;
    logic invert_lemo;
    logic disable_veto;
    logic enable_reset;
    logic write_ts;
    logic load_number;
    logic [payload_width-1:0] load_value;
    logic [payload_width-1:0] trigger_number;
    logic push;
    tlu_event_word push_word;
    logic pop;
    tlu_event_word head_word;
    logic empty;
    logic [fifo_level_width-1:0] level;
    logic [lost_count_width-1:0] lost_count;

    tlu_trigger_unit tlu_trigger_unit_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .rj45_trigger(rj45_trigger),
        .lemo_trigger(lemo_trigger),
        .rj45_reset(rj45_reset),
        .lemo_reset(lemo_reset),
        .ext_veto(ext_veto),
        .mode(mode),
        .invert_lemo(invert_lemo),
        .disable_veto(disable_veto),
        .enable_reset(enable_reset),
        .write_ts(write_ts),
        .load_number(load_number),
        .load_value(load_value),
        .rj45_enabled(rj45_enabled),
        .tlu_busy(tlu_busy),
        .push(push),
        .push_word(push_word),
        .trigger_number(trigger_number)
    );

    tlu_event_fifo tlu_event_fifo_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .push(push),
        .push_word(push_word),
        .pop(pop),
        .head_word(head_word),
        .empty(empty),
        .level(level),
        .lost_count(lost_count)
    );

    tlu_wb_regs tlu_wb_regs_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .mode(mode),
        .invert_lemo(invert_lemo),
        .disable_veto(disable_veto),
        .enable_reset(enable_reset),
        .write_ts(write_ts),
        .load_number(load_number),
        .load_value(load_value),
        .pop(pop),
        .head_word(head_word),
        .empty(empty),
        .level(level),
        .lost_count(lost_count),
        .trigger_number(trigger_number)
    );

endmodule

//--- design/tlu_wb_regs.sv
// Wishbone register block of the TLU controller
//   classic slave with single-cycle ack
//   control byte and trigger number preset bytes
//   readback of status, FIFO head and trigger number snapshot
//   FIFO pop on the read of the top data byte

`timescale 1ns/10ps

module tlu_wb_regs (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [tlu_pkg::wb_adr_width-1:0] wb_adr,
    input  logic [tlu_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [tlu_pkg::wb_data_width-1:0] wb_dat_r,
    output logic wb_ack,
    output logic [1:0] mode,
    output logic invert_lemo,
    output logic disable_veto,
    output logic enable_reset,
    output logic write_ts,
    output logic load_number,
    output logic [tlu_pkg::payload_width-1:0] load_value,
    output logic pop,
    input  tlu_pkg::tlu_event_word head_word,
    input  logic empty,
    input  logic [tlu_pkg::fifo_level_width-1:0] level,
    input  logic [tlu_pkg::lost_count_width-1:0] lost_count,
    input  logic [tlu_pkg::payload_width-1:0] trigger_number
);
    import tlu_pkg::*;

    logic bus_req;
    logic [wb_data_width-1:0] ctrl_reg;
    logic [wb_data_width-1:0] set_number_bytes [4];
    logic [payload_width-1:0] number_snapshot;
    logic [event_width-1:0] snapshot_word;
    logic [wb_data_width-1:0] rd_byte;

    // ack goes out on the clock after a new request
    assign bus_req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wb_ack <= 1'b0;
            load_number <= 1'b0;
            pop <= 1'b0;
            ctrl_reg <= '0;
            for (int i = 0; i < 4; i++)
                set_number_bytes[i] <= '0;
        end
        else
        begin
            wb_ack <= bus_req;
            load_number <= bus_req && wb_we && wb_adr == reg_set_number + 4'd3;
            pop <= bus_req && !wb_we && wb_adr == reg_fifo_data + 4'd3 && !empty;
            if (bus_req && wb_we)
            begin
                if (wb_adr == reg_ctrl)
                    ctrl_reg <= wb_dat_w;
                else if (wb_adr inside {[reg_set_number : reg_set_number + 4'd3]})
                    set_number_bytes[2'(wb_adr - reg_set_number)] <= wb_dat_w;
            end
        end
    end

    assign mode = ctrl_reg[ctrl_mode_msb:ctrl_mode_lsb];
    assign invert_lemo = ctrl_reg[ctrl_invert_lemo];
    assign disable_veto = ctrl_reg[ctrl_disable_veto];
    assign enable_reset = ctrl_reg[ctrl_enable_reset];
    assign write_ts = ctrl_reg[ctrl_write_ts];

    // top preset bit has no place in the 31-bit number
    assign load_value = {set_number_bytes[3][6:0], set_number_bytes[2],
                         set_number_bytes[1], set_number_bytes[0]};

    assign snapshot_word = {1'b0, number_snapshot};

    always_comb
    begin
        rd_byte = '0;
        case (wb_adr) inside
            reg_ctrl: rd_byte = ctrl_reg;
            reg_lost: rd_byte = lost_count;
            [reg_set_number : reg_set_number + 4'd3]:
                rd_byte = set_number_bytes[2'(wb_adr - reg_set_number)];
            reg_fifo_status: rd_byte = {level, 3'b000, empty};
            [reg_fifo_data : reg_fifo_data + 4'd3]:
                rd_byte = head_word[{wb_adr[1:0], 3'b000} +: 8];
            reg_trigger_number: rd_byte = trigger_number[7:0];
            [reg_trigger_number + 4'd1 : reg_trigger_number + 4'd3]:
                rd_byte = snapshot_word[{wb_adr[1:0], 3'b000} +: 8];
            default: rd_byte = '0;
        endcase
    end

    // read data and snapshot captured with the ack
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wb_dat_r <= '0;
            number_snapshot <= '0;
        end
        else
        begin
            if (bus_req)
                wb_dat_r <= rd_byte;
            if (bus_req && !wb_we && wb_adr == reg_trigger_number)
                number_snapshot <= trigger_number;
        end
    end

    ack_needs_request: assert property (@(posedge BUS_CLK) disable iff (RST)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without a bus request");

endmodule

//--- design/tlu_event_fifo.sv
// Event FIFO of the TLU controller
//   8-word circular buffer with read and write pointers
//   fill level and empty flag
//   saturating count of events dropped while full

`timescale 1ns/10ps

module tlu_event_fifo (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic push,
    input  tlu_pkg::tlu_event_word push_word,
    input  logic pop,
    output tlu_pkg::tlu_event_word head_word,
    output logic empty,
    output logic [tlu_pkg::fifo_level_width-1:0] level,
    output logic [tlu_pkg::lost_count_width-1:0] lost_count
);
    import tlu_pkg::*;

    tlu_event_word mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = level == fifo_level_width'(fifo_depth);
    assign empty = level == '0;
    assign do_pop = pop && !empty;
    // a pop in the same cycle frees the slot for the push
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge BUS_CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_word;
    end

    assign head_word = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
            if (push && !do_push && lost_count != '1)
                lost_count <= lost_count + 1'b1;
        end
    end

    no_pop_when_empty: assert property (@(posedge BUS_CLK) disable iff (RST) pop |-> !empty)
        else $error("pop while the event FIFO is empty");

    level_in_range: assert property (@(posedge BUS_CLK) disable iff (RST)
        level <= fifo_level_width'(fifo_depth))
        else $error("event FIFO level above depth");

endmodule

//--- design/tlu_trigger_unit.sv
// Trigger unit of the TLU controller
//   LEMO trigger inversion and two-stage pin synchronizer
//   RJ45 / LEMO port selection
//   trigger acceptance with veto and busy handshake
//   trigger number and free-running timestamp counters

`timescale 1ns/10ps

module tlu_trigger_unit (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic rj45_trigger,
    input  logic lemo_trigger,
    input  logic rj45_reset,
    input  logic lemo_reset,
    input  logic ext_veto,
    input  logic [1:0] mode,
    input  logic invert_lemo,
    input  logic disable_veto,
    input  logic enable_reset,
    input  logic write_ts,
    input  logic load_number,
    input  logic [tlu_pkg::payload_width-1:0] load_value,
    output logic rj45_enabled,
    output logic tlu_busy,
    output logic push,
    output tlu_pkg::tlu_event_word push_word,
    output logic [tlu_pkg::payload_width-1:0] trigger_number
);
    import tlu_pkg::*;

    logic lemo_trigger_mod;
    logic [4:0] sync_ff [sync_stages];
    logic rj45_trig_s;
    logic lemo_trig_s;
    logic rj45_rst_s;
    logic lemo_rst_s;
    logic veto_s;
    logic trig_sel;
    logic rst_sel;
    logic trig_prev;
    logic rst_prev;
    logic trig_rise;
    logic reset_rise;
    logic accept;
    logic [payload_width-1:0] timestamp;

    assign lemo_trigger_mod = invert_lemo ? ~lemo_trigger : lemo_trigger;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            for (int i = 0; i < sync_stages; i++)
                sync_ff[i] <= '0;
        end
        else
        begin
            sync_ff[0] <= {rj45_trigger, lemo_trigger_mod, rj45_reset, lemo_reset, ext_veto};
            for (int i = 1; i < sync_stages; i++)
                sync_ff[i] <= sync_ff[i-1];
        end
    end

    assign {rj45_trig_s, lemo_trig_s, rj45_rst_s, lemo_rst_s, veto_s} = sync_ff[sync_stages-1];

    // unplugged RJ45 reads high on both lines
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            rj45_enabled <= 1'b0;
        else if (mode == mode_disabled || (rj45_trig_s && rj45_rst_s && !rj45_enabled))
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= 1'b1;
    end

    assign trig_sel = rj45_enabled ? rj45_trig_s : lemo_trig_s;
    assign rst_sel = rj45_enabled ? rj45_rst_s : lemo_rst_s;

    // edge registers
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trig_prev <= 1'b0;
            rst_prev <= 1'b0;
        end
        else
        begin
            trig_prev <= trig_sel;
            rst_prev <= rst_sel;
        end
    end

    assign trig_rise = trig_sel && !trig_prev;
    assign reset_rise = rst_sel && !rst_prev && enable_reset;
    assign accept = trig_rise && mode != mode_disabled && !tlu_busy && (!veto_s || disable_veto);

    // handshake modes hold busy until the trigger line is released
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            tlu_busy <= 1'b0;
        else if (accept && mode != mode_no_handshake)
            tlu_busy <= 1'b1;
        else if (!trig_sel)
            tlu_busy <= 1'b0;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            trigger_number <= '0;
        else if (load_number)
            trigger_number <= load_value;
        else if (reset_rise)
            trigger_number <= '0;
        else if (accept && trigger_number != '1)
            trigger_number <= trigger_number + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    assign push = accept;

    always_comb
    begin
        push_word = '0;
        if (write_ts)
        begin
            push_word.as_timestamp.kind = 1'b0;
            push_word.as_timestamp.timestamp = timestamp;
        end
        else
        begin
            push_word.as_number.kind = 1'b1;
            push_word.as_number.number = trigger_number;
        end
    end

    // busy only comes from an accept made in a handshake mode
    busy_needs_handshake: assert property (@(posedge BUS_CLK) disable iff (RST)
        $rose(tlu_busy) |-> $past(mode) != mode_disabled && $past(mode) != mode_no_handshake)
        else $error("tlu_busy rose outside the handshake modes");

endmodule

//--- design/tlu_pkg.sv
// Shared definitions for the TLU controller
//   bus and payload widths
//   event FIFO sizing and synchronizer depth
//   trigger mode codes
//   register map and control register bit positions
//   event word with number and timestamp views

package tlu_pkg;

    // bus and payload widths
    localparam int wb_adr_width = 4;
    localparam int wb_data_width = 8;
    localparam int event_width = 32;
    localparam int payload_width = event_width - 1;

    // event FIFO
    localparam int fifo_depth = 8;
    localparam int fifo_level_width = 4;
    localparam int lost_count_width = 8;

    // input synchronizer depth
    localparam int sync_stages = 2;

    // trigger modes
    // 2'b11 acts like the simple handshake
    localparam logic [1:0] mode_disabled = 2'b00;
    localparam logic [1:0] mode_no_handshake = 2'b01;
    localparam logic [1:0] mode_simple_handshake = 2'b10;

    // register map
    // multi-byte values least significant byte first
    localparam logic [wb_adr_width-1:0] reg_ctrl = 4'd0;
    localparam logic [wb_adr_width-1:0] reg_lost = 4'd1;
    localparam logic [wb_adr_width-1:0] reg_set_number = 4'd2;
    localparam logic [wb_adr_width-1:0] reg_fifo_status = 4'd6;
    localparam logic [wb_adr_width-1:0] reg_fifo_data = 4'd8;
    localparam logic [wb_adr_width-1:0] reg_trigger_number = 4'd12;

    // control register fields
    localparam int ctrl_mode_lsb = 0;
    localparam int ctrl_mode_msb = 1;
    localparam int ctrl_invert_lemo = 2;
    localparam int ctrl_disable_veto = 3;
    localparam int ctrl_enable_reset = 4;
    localparam int ctrl_write_ts = 5;

    typedef struct packed {
        logic kind;
        logic [payload_width-1:0] number;
    } tlu_number_view;

    typedef struct packed {
        logic kind;
        logic [payload_width-1:0] timestamp;
    } tlu_timestamp_view;

    // bit 31 tells the two decodings of a FIFO word apart
    typedef union packed {
        tlu_number_view as_number;
        tlu_timestamp_view as_timestamp;
    } tlu_event_word;

endpackage
